/* fft_front.f */
+incdir+design
design/fft_types_pkg.sv
design/sdf_sched_pkg.sv
design/delay_line.sv
design/sdf_stage_tw.sv
design/sdf_stage_mj.sv
design/fft_front.sv
dv/fft_front_tb.sv

/* dv/fft_front_cases.mem */
// each case: one line with the idle gap before the block in cycles, then 8 beat lines
// beat line: lane-0 input re, input im, expected output re, expected output im (16-bit hex)
// impulse on beat 0
0003
0064 0000 0064 0000
0000 0000 0000 0000
0000 0000 0064 0000
0000 0000 0000 0000
0000 0000 0064 0000
0000 0000 0000 0000
0000 0000 0064 0000
0000 0000 0000 0000
// exact half-up rounding on W8^1 and W8^3, -j swap
0000
000b 0016 0011 0011
0022 004c 010c 0034
0005 fff9 0007 001f
00a4 000e 007c 0104
0001 0002 0003 000f
ffe2 000c 005b ffa6
0000 0000 0011 0019
0064 ffce 005a ffa5
// full scale, back to back
0000
03ff fc01 0000 07fe
03ff 03ff 0000 0000
fc01 03ff 0000 f802
fc01 fc01 0000 0000
fc01 03ff 07fe 0000
fc01 fc01 0b4d 0b4d
03ff 03ff 07fe f004
03ff 03ff f4b3 f4b3
// small mixed values after a long gap
0006
fffb 0003 0000 000b
0007 fffe 000a 0003
0000 0009 fffa ffff
ffff ffff 0005 0004
0002 0002 0005 0004
fffc 0006 0008 fffa
0003 fffd ffed fffe
0008 0000 ffec 0004

/* dv/fft_front_tb.sv */
`include "fft_consts.svh"

module fft_front_tb;

    localparam int NUM_CASES  = 4;
    localparam int CASE_WORDS = 1 + 4 * `FFT_BLOCK;
    localparam int DRAIN_WAIT = 40;

    logic                     clk;
    logic                     rstn;
    logic                     di_en;
    fft_types_pkg::beat_in_t  di;
    logic                     do_en;
    fft_types_pkg::beat_out_t dout;

    logic [15:0]              case_words [NUM_CASES * CASE_WORDS];
    logic [31:0]              rng;
    int                       cyc = 0;

    // one block of stimulus and its expected output
    fft_types_pkg::beat_in_t  blk_in  [`FFT_BLOCK];
    fft_types_pkg::beat_out_t blk_exp [`FFT_BLOCK];
    int                       in_re   [`FFT_BLOCK];
    int                       in_im   [`FFT_BLOCK];
    int                       out_re  [`FFT_BLOCK];
    int                       out_im  [`FFT_BLOCK];

    fft_types_pkg::beat_out_t exp_q     [$];
    int                       exp_cyc_q [$];

    fft_front uut (
        .clk   (clk),
        .rstn  (rstn),
        .di_en (di_en),
        .di    (di),
        .do_en (do_en),
        .dout  (dout)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic stop_on_failure();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input logic signed [31:0] got, input logic signed [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // round half up to the nearest integer after the fractional shift
    function automatic int round_q8(input int v);
        return (v + (1 << (`FFT_TW_FRAC - 1))) >>> `FFT_TW_FRAC;
    endfunction

    // 8-point front end for one lane from in_re/in_im to out_re/out_im
    task automatic fft8_reference();
        int m_re [`FFT_BLOCK];
        int m_im [`FFT_BLOCK];
        int d_re;
        int d_im;
        int t_re;
        int t_im;
        sdf_sched_pkg::twiddle_e tw;
        for (int n = 0; n < 4; n++) begin
            m_re[n] = in_re[n] + in_re[n+4];
            m_im[n] = in_im[n] + in_im[n+4];
            d_re = in_re[n] - in_re[n+4];
            d_im = in_im[n] - in_im[n+4];
            tw = sdf_sched_pkg::twiddle_e'(n);
            case (tw)
                sdf_sched_pkg::tw_one: begin
                    m_re[n+4] = d_re;
                    m_im[n+4] = d_im;
                end
                sdf_sched_pkg::tw_w8: begin
                    m_re[n+4] = round_q8(`FFT_TW_COS * (d_re + d_im));
                    m_im[n+4] = round_q8(`FFT_TW_COS * (d_im - d_re));
                end
                sdf_sched_pkg::tw_mj: begin
                    m_re[n+4] = d_im;
                    m_im[n+4] = -d_re;
                end
                default: begin
                    m_re[n+4] = round_q8(`FFT_TW_COS * (d_im - d_re));
                    m_im[n+4] = round_q8(`FFT_TW_COS * (-d_re - d_im));
                end
            endcase
        end
        // second butterfly on each half with the odd difference times -j
        for (int b = 0; b < `FFT_BLOCK; b += 4) begin
            out_re[b]   = m_re[b] + m_re[b+2];
            out_im[b]   = m_im[b] + m_im[b+2];
            out_re[b+1] = m_re[b+1] + m_re[b+3];
            out_im[b+1] = m_im[b+1] + m_im[b+3];
            out_re[b+2] = m_re[b] - m_re[b+2];
            out_im[b+2] = m_im[b] - m_im[b+2];
            t_re = m_re[b+1] - m_re[b+3];
            t_im = m_im[b+1] - m_im[b+3];
            out_re[b+3] = t_im;
            out_im[b+3] = -t_re;
        end
    endtask

    task automatic build_block(input int c);
        int base;
        int idx;
        base = c * CASE_WORDS + 1;
        for (int n = 0; n < `FFT_BLOCK; n++) begin
            idx = base + 4 * n;
            blk_in[n][0].re = case_words[idx][`FFT_IN_W-1:0];
            blk_in[n][0].im = case_words[idx+1][`FFT_IN_W-1:0];
            for (int l = 1; l < `FFT_LANES; l++) begin
                rng = xorshift32(rng);
                blk_in[n][l].re = rng[`FFT_IN_W-1:0];
                rng = xorshift32(rng);
                blk_in[n][l].im = rng[`FFT_IN_W-1:0];
            end
        end
        for (int l = 0; l < `FFT_LANES; l++) begin
            for (int n = 0; n < `FFT_BLOCK; n++) begin
                in_re[n] = $signed(blk_in[n][l].re);
                in_im[n] = $signed(blk_in[n][l].im);
            end
            fft8_reference();
            for (int n = 0; n < `FFT_BLOCK; n++) begin
                // lane 0 expected values from the file cross-check the model
                if (l == 0) begin
                    idx = base + 4 * n;
                    check_value(out_re[n], $signed(case_words[idx+2]),
                                $sformatf("model case %0d beat %0d re", c, n));
                    check_value(out_im[n], $signed(case_words[idx+3]),
                                $sformatf("model case %0d beat %0d im", c, n));
                end
                blk_exp[n][l].re = out_re[n][`FFT_OUT_W-1:0];
                blk_exp[n][l].im = out_im[n][`FFT_OUT_W-1:0];
            end
        end
    endtask

    task automatic drive_block();
        for (int n = 0; n < `FFT_BLOCK; n++) begin
            @(posedge clk);
            #2;
            if (n == 0) begin
                for (int k = 0; k < `FFT_BLOCK; k++) begin
                    exp_q.push_back(blk_exp[k]);
                    exp_cyc_q.push_back(cyc + 8 + k);
                end
            end
            di_en = 1'b1;
            di    = blk_in[n];
        end
    endtask

    task automatic check_output_beat();
        fft_types_pkg::beat_out_t exp_beat;
        int exp_cyc;
        if (exp_q.size() == 0) begin
            $display("do_en went high at time %0t with no output beat expected", $time);
            stop_on_failure();
        end else begin
            exp_beat = exp_q.pop_front();
            exp_cyc  = exp_cyc_q.pop_front();
            check_value(cyc, exp_cyc, "cycle of do_en beat");
            for (int l = 0; l < `FFT_LANES; l++) begin
                check_value($signed(dout[l].re), $signed(exp_beat[l].re),
                            $sformatf("dout lane %0d re", l));
                check_value($signed(dout[l].im), $signed(exp_beat[l].im),
                            $sformatf("dout lane %0d im", l));
            end
        end
    endtask

    always @(negedge clk) begin
        if (rstn && do_en === 1'b1) begin
            check_output_beat();
        end
    end

    initial begin
        int gap;
        int wait_cnt;
        rstn  = 1'b0;
        di_en = 1'b0;
        di    = '0;
        rng   = 32'hdf2c_0f1d;
        $readmemh("dv/fft_front_cases.mem", case_words);
        if ($isunknown(case_words[NUM_CASES * CASE_WORDS - 1])) begin
            $display("the case file dv/fft_front_cases.mem is missing or too short");
            stop_on_failure();
        end
        repeat (5) @(posedge clk);
        #2;
        rstn = 1'b1;
        repeat (20) begin
            @(negedge clk);
            check_value(do_en, 0, "do_en before any input");
            check_value(uut.mid_en, 0, "mid_en before any input");
        end
        for (int c = 0; c < NUM_CASES; c++) begin
            gap = case_words[c * CASE_WORDS];
            repeat (gap) begin
                @(posedge clk);
                #2;
                di_en = 1'b0;
                di    = '0;
            end
            build_block(c);
            drive_block();
        end
        @(posedge clk);
        #2;
        di_en = 1'b0;
        di    = '0;
        // last block drains with no input
        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < DRAIN_WAIT) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: no output arrived for %0d expected beats within %0d cycles",
                     exp_q.size(), DRAIN_WAIT);
            stop_on_failure();
        end else begin
            repeat (12) @(posedge clk);
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

/* design/fft_front.sv */
module fft_front (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     di_en,
    input  fft_types_pkg::beat_in_t  di,
    output logic                     do_en,
    output fft_types_pkg::beat_out_t dout
);

    // stage one result 5 cycles behind di_en
    logic                     mid_en;
    fft_types_pkg::beat_mid_t mid;

    sdf_stage_tw u_stage_tw (
        .clk    (clk),
        .rstn   (rstn),
        .in_en  (di_en),
        .din    (di),
        .out_en (mid_en),
        .dout   (mid)
    );

    // another 3 cycles to do_en
    sdf_stage_mj u_stage_mj (
        .clk    (clk),
        .rstn   (rstn),
        .in_en  (mid_en),
        .din    (mid),
        .out_en (do_en),
        .dout   (dout)
    );

endmodule

/* design/sdf_stage_mj.sv */
`include "fft_consts.svh"

module sdf_stage_mj (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     in_en,
    input  fft_types_pkg::beat_mid_t din,
    output logic                     out_en,
    output fft_types_pkg::beat_out_t dout
);

    localparam int OUT_W = `FFT_OUT_W;

    sdf_sched_pkg::phase_t    phase;
    logic                     drain;
    logic                     drain_odd;
    logic                     load_half;
    logic                     shift;
    fft_types_pkg::beat_out_t dl_in;
    fft_types_pkg::beat_out_t dl_out;
    fft_types_pkg::beat_out_t out_next;

    // position within the current group of four
    assign load_half = (phase[1:0] < `FFT_MJ_DEPTH);
    assign shift     = in_en | drain;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase     <= '0;
            drain     <= 1'b0;
            drain_odd <= 1'b0;
            out_en    <= 1'b0;
        end else begin
            if (in_en) begin
                phase <= phase + 1'b1;
            end
            if (in_en && phase[1:0] == 2 * `FFT_MJ_DEPTH - 1) begin
                drain     <= 1'b1;
                drain_odd <= 1'b0;
            end else if (drain) begin
                drain_odd <= ~drain_odd;
                drain     <= ~drain_odd;
            end
            out_en <= (in_en && !load_half) || drain;
        end
    end

    delay_line #(
        .DEPTH  (`FFT_MJ_DEPTH),
        .WORD_W ($bits(fft_types_pkg::beat_out_t))
    ) u_delay (
        .clk   (clk),
        .rstn  (rstn),
        .shift (shift),
        .din   (dl_in),
        .dout  (dl_out)
    );

    always_comb begin
        logic signed [OUT_W-1:0] cur_re;
        logic signed [OUT_W-1:0] cur_im;
        logic signed [OUT_W-1:0] old_re;
        logic signed [OUT_W-1:0] old_im;
        for (int l = 0; l < `FFT_LANES; l++) begin
            cur_re = OUT_W'(din[l].re);
            cur_im = OUT_W'(din[l].im);
            old_re = dl_out[l].re;
            old_im = dl_out[l].im;
            if (load_half) begin
                dl_in[l].re = cur_re;
                dl_in[l].im = cur_im;
            end else begin
                dl_in[l].re = old_re - cur_re;
                dl_in[l].im = old_im - cur_im;
            end
            if (!drain) begin
                out_next[l].re = old_re + cur_re;
                out_next[l].im = old_im + cur_im;
            end else if (drain_odd) begin
                // times -j
                out_next[l].re = old_im;
                out_next[l].im = -old_re;
            end else begin
                out_next[l] = dl_out[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        dout <= out_next;
    end

    a_group_whole: assert property (@(posedge clk) disable iff (!rstn)
        (in_en && phase[1:0] == 2'd0) |-> in_en [*(2 * `FFT_MJ_DEPTH)]);

endmodule

/* design/sdf_stage_tw.sv */
`include "fft_consts.svh"

module sdf_stage_tw (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     in_en,
    input  fft_types_pkg::beat_in_t  din,
    output logic                     out_en,
    output fft_types_pkg::beat_mid_t dout
);

    localparam int MID_W  = `FFT_MID_W;
    localparam int SUM_W  = MID_W + 1;
    // sum width times a 9-bit signed coefficient, plus headroom for the bias
    localparam int PROD_W = SUM_W + 10;

    sdf_sched_pkg::phase_t    phase;
    logic                     drain;
    logic [1:0]               drain_cnt;
    sdf_sched_pkg::twiddle_e  tw_sel;
    logic                     load_half;
    logic                     shift;
    fft_types_pkg::beat_mid_t dl_in;
    fft_types_pkg::beat_mid_t dl_out;
    fft_types_pkg::beat_mid_t out_next;

    // round half up, then drop the fraction
    function automatic logic signed [MID_W-1:0] tw_round(input logic signed [PROD_W-1:0] p);
        logic signed [PROD_W-1:0] biased;
        biased = p + PROD_W'(1 << (`FFT_TW_FRAC - 1));
        return MID_W'(biased >>> `FFT_TW_FRAC);
    endfunction

    assign load_half = (phase < `FFT_TW_DEPTH);
    assign shift     = in_en | drain;
    assign tw_sel    = sdf_sched_pkg::twiddle_e'(drain_cnt);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            phase     <= '0;
            drain     <= 1'b0;
            drain_cnt <= '0;
            out_en    <= 1'b0;
        end else begin
            if (in_en) begin
                phase <= phase + 1'b1;
            end
            // last beat of a block kicks off the difference drain
            if (in_en && phase == `FFT_BLOCK - 1) begin
                drain     <= 1'b1;
                drain_cnt <= '0;
            end else if (drain) begin
                drain_cnt <= drain_cnt + 1'b1;
                drain     <= (drain_cnt != 2'd3);
            end
            out_en <= (in_en && !load_half) || drain;
        end
    end

    delay_line #(
        .DEPTH  (`FFT_TW_DEPTH),
        .WORD_W ($bits(fft_types_pkg::beat_mid_t))
    ) u_delay (
        .clk   (clk),
        .rstn  (rstn),
        .shift (shift),
        .din   (dl_in),
        .dout  (dl_out)
    );

    always_comb begin
        logic signed [MID_W-1:0]  cur_re;
        logic signed [MID_W-1:0]  cur_im;
        logic signed [MID_W-1:0]  old_re;
        logic signed [MID_W-1:0]  old_im;
        logic signed [SUM_W-1:0]  a;
        logic signed [SUM_W-1:0]  b;
        logic signed [PROD_W-1:0] pa;
        logic signed [PROD_W-1:0] pb;
        fft_types_pkg::cplx_mid_t rot;
        for (int l = 0; l < `FFT_LANES; l++) begin
            cur_re = MID_W'(din[l].re);
            cur_im = MID_W'(din[l].im);
            old_re = dl_out[l].re;
            old_im = dl_out[l].im;
            // beats 4-7 leave their difference behind for the drain
            if (load_half) begin
                dl_in[l].re = cur_re;
                dl_in[l].im = cur_im;
            end else begin
                dl_in[l].re = old_re - cur_re;
                dl_in[l].im = old_im - cur_im;
            end
            a  = SUM_W'(old_re) + SUM_W'(old_im);
            b  = SUM_W'(old_im) - SUM_W'(old_re);
            pa = PROD_W'(a) * PROD_W'(`FFT_TW_COS);
            pb = PROD_W'(b) * PROD_W'(`FFT_TW_COS);
            case (tw_sel)
                sdf_sched_pkg::tw_one: begin
                    rot.re = old_re;
                    rot.im = old_im;
                end
                sdf_sched_pkg::tw_w8: begin
                    rot.re = tw_round(pa);
                    rot.im = tw_round(pb);
                end
                sdf_sched_pkg::tw_mj: begin
                    rot.re = old_im;
                    rot.im = -old_re;
                end
                sdf_sched_pkg::tw_w8_3: begin
                    rot.re = tw_round(pb);
                    // half-up is not symmetric, so -a gets its own rounding
                    rot.im = tw_round(-pa);
                end
            endcase
            if (drain) begin
                out_next[l] = rot;
            end else begin
                out_next[l].re = old_re + cur_re;
                out_next[l].im = old_im + cur_im;
            end
        end
    end

    always_ff @(posedge clk) begin
        dout <= out_next;
    end

    a_block_whole: assert property (@(posedge clk) disable iff (!rstn)
        (in_en && phase == '0) |-> in_en [*`FFT_BLOCK]);

    // drain runs on its own for a bounded time after input stops
    a_drain_bounded: assert property (@(posedge clk) disable iff (!rstn)
        (out_en && !in_en) [*`FFT_BLOCK] |=> !(out_en && !in_en));

endmodule

/* design/delay_line.sv */
module delay_line #(
    parameter int DEPTH  = 4,
    parameter int WORD_W = 32
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              shift,
    input  logic [WORD_W-1:0] din,
    output logic [WORD_W-1:0] dout
);

    logic [WORD_W-1:0] chain [DEPTH];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                chain[i] <= '0;
            end
        end else if (shift) begin
            chain[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                chain[i] <= chain[i-1];
            end
        end
    end

    // oldest entry
    assign dout = chain[DEPTH-1];

endmodule

/* design/sdf_sched_pkg.sv */
`include "fft_consts.svh"

package sdf_sched_pkg;

    // rotation applied to each drained difference in drain order
    typedef enum logic [1:0] {
        tw_one,
        tw_w8,
        tw_mj,
        tw_w8_3
    } twiddle_e;

    // beat position within a block
    typedef logic [$clog2(`FFT_BLOCK)-1:0] phase_t;

endpackage

/* design/fft_types_pkg.sv */
`include "fft_consts.svh"

package fft_types_pkg;

    typedef struct packed {
        logic signed [`FFT_IN_W-1:0] re;
        logic signed [`FFT_IN_W-1:0] im;
    } cplx_in_t;

    // stage one output with one bit of growth plus the twiddle gain
    typedef struct packed {
        logic signed [`FFT_MID_W-1:0] re;
        logic signed [`FFT_MID_W-1:0] im;
    } cplx_mid_t;

    typedef struct packed {
        logic signed [`FFT_OUT_W-1:0] re;
        logic signed [`FFT_OUT_W-1:0] im;
    } cplx_out_t;

    typedef cplx_in_t  [`FFT_LANES-1:0] beat_in_t;
    typedef cplx_mid_t [`FFT_LANES-1:0] beat_mid_t;
    typedef cplx_out_t [`FFT_LANES-1:0] beat_out_t;

endpackage

/* design/fft_consts.svh */
`ifndef FFT_CONSTS_SVH
`define FFT_CONSTS_SVH

`define FFT_LANES    16
`define FFT_IN_W     11
`define FFT_MID_W    13
`define FFT_OUT_W    14
`define FFT_BLOCK    8

// feedback delays in beats
`define FFT_TW_DEPTH 4
`define FFT_MJ_DEPTH 2

// cos(pi/4) with 8 fractional bits
`define FFT_TW_COS   181
`define FFT_TW_FRAC  8

`endif
